// ==== logic/blit_cfg.svh ====
`ifndef BLIT_CFG_SVH
`define BLIT_CFG_SVH

// VRAM data word width
`define BLIT_WORD_W   16

// VRAM word address width
`define BLIT_ADDR_W   16

// nibbles per word, one write-mask bit each
`define BLIT_NIBBLES  4

// host register number width
`define BLIT_REG_W    4

`endif

// ==== logic/blit_pkg.sv ====
`default_nettype none

`include "blit_cfg.svh"

package blit_pkg;

    typedef logic [`BLIT_WORD_W-1:0]  word_t;
    typedef logic [`BLIT_ADDR_W-1:0]  addr_t;
    typedef logic [`BLIT_NIBBLES-1:0] nib_mask_t;

    // host register numbers, 7 left free
    typedef enum logic [`BLIT_REG_W-1:0] {
        CTRL  = 0,      // s_const, transp, transp_t
        ANDC  = 1,
        XOR   = 2,
        MOD_S = 3,
        SRC_S = 4,
        MOD_D = 5,
        DST_D = 6,
        LINES = 8,      // count minus one
        WORDS = 9       // write queues the blit
    } blit_reg_e;

    typedef enum logic [2:0] {
        IDLE,
        SETUP,
        LINE_BEG,
        RD_S,
        WR_D,
        LINE_END
    } blit_state_e;

    typedef struct packed {
        logic       s_const;    // use src_s as constant source
        logic       transp;     // 4-bit transparency enable
        logic [7:0] transp_t;   // transparent nibbles, upper for odd
        word_t      andc;
        word_t      xorv;
        word_t      mod_s;
        word_t      src_s;
        word_t      mod_d;
        word_t      dst_d;
        word_t      lines;
        word_t      words;
    } blit_params_t;

    typedef struct packed {
        logic       sel;        // held until ack
        logic       wr;
        nib_mask_t  wr_mask;
        addr_t      addr;
        word_t      data;
    } vram_req_t;

endpackage

`default_nettype wire

// ==== logic/blit_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

module blit_regs (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   reg_wr_i,       // one register write per strobe
    input  wire blit_pkg::blit_reg_e    reg_num_i,
    input  wire blit_pkg::word_t        reg_data_i,
    input  wire logic                   setup_i,        // sequencer takes the queued blit
    output logic                        queued_o,
    output blit_pkg::blit_params_t      active_o
);
    import blit_pkg::*;

    blit_params_t   queued_set;     // host side, rewritable while a blit runs
    logic           words_wr;

    assign words_wr = reg_wr_i && (reg_num_i == WORDS);

    always_ff @(posedge clk) begin
        if (reg_wr_i) begin
            case (reg_num_i)
                CTRL: begin
                    queued_set.s_const  <= reg_data_i[0];
                    queued_set.transp   <= reg_data_i[4];
                    queued_set.transp_t <= reg_data_i[15:8];
                end
                ANDC: begin
                    queued_set.andc     <= reg_data_i;
                end
                XOR: begin
                    queued_set.xorv     <= reg_data_i;
                end
                MOD_S: begin
                    queued_set.mod_s    <= reg_data_i;
                end
                SRC_S: begin
                    queued_set.src_s    <= reg_data_i;
                end
                MOD_D: begin
                    queued_set.mod_d    <= reg_data_i;
                end
                DST_D: begin
                    queued_set.dst_d    <= reg_data_i;
                end
                LINES: begin
                    queued_set.lines    <= reg_data_i;
                end
                WORDS: begin
                    queued_set.words    <= reg_data_i;
                end
                default: begin
                end
            endcase
        end
    end

    // a WORDS write in the setup cycle keeps the slot full
    always_ff @(posedge clk) begin
        if (reset_i) begin
            queued_o <= 1'b0;
        end else if (words_wr) begin
            queued_o <= 1'b1;
        end else if (setup_i) begin
            queued_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (setup_i) begin
            active_o <= queued_set;                 // old set, before this cycle's write
        end
    end

endmodule

`default_nettype wire

// ==== logic/blit_seq.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "blit_cfg.svh"

module blit_seq (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   queued_i,
    input  wire blit_pkg::blit_params_t params_i,
    input  wire logic                   vram_ack_i,
    input  wire blit_pkg::word_t        vram_data_i,    // valid in the ack cycle
    output logic                        setup_o,
    output blit_pkg::word_t             val_s_o,
    output logic                        sel_o,
    output logic                        wr_o,
    output blit_pkg::addr_t             addr_o,
    output logic                        busy_o,
    output logic                        done_o
);
    import blit_pkg::*;

    blit_state_e            state;
    addr_t                  src_run;        // next source word
    addr_t                  dst_run;        // next destination word
    logic [`BLIT_WORD_W:0]  line_cnt;       // msb is underflow, last line
    logic [`BLIT_WORD_W:0]  word_cnt;       // msb is underflow, last word
    logic                   last_line;
    logic                   last_word;
    logic                   advance;

    assign last_line = line_cnt[`BLIT_WORD_W];
    assign last_word = word_cnt[`BLIT_WORD_W];
    assign advance   = !sel_o || vram_ack_i;    // stall while a request waits
    assign busy_o    = (state != IDLE);

    // active set loads on the edge into SETUP, sel is low in both states
    assign setup_o = queued_i && ((state == IDLE) || (state == LINE_END && last_line));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state  <= IDLE;
            sel_o  <= 1'b0;
            wr_o   <= 1'b0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (advance) begin
                case (state)
                    IDLE: begin
                        if (queued_i) begin
                            state <= SETUP;
                        end
                    end
                    SETUP: begin
                        state <= LINE_BEG;
                    end
                    LINE_BEG: begin
                        sel_o <= 1'b1;
                        wr_o  <= params_i.s_const;          // constant fill skips the read
                        state <= params_i.s_const ? WR_D : RD_S;
                    end
                    RD_S: begin
                        wr_o  <= 1'b1;
                        state <= WR_D;
                    end
                    WR_D: begin
                        if (last_word) begin
                            sel_o <= 1'b0;
                            wr_o  <= 1'b0;
                            state <= LINE_END;
                        end else if (!params_i.s_const) begin
                            wr_o  <= 1'b0;
                            state <= RD_S;
                        end
                    end
                    LINE_END: begin
                        if (last_line) begin
                            done_o <= 1'b1;
                            state  <= queued_i ? SETUP : IDLE;  // next blit starts directly
                        end else begin
                            state  <= LINE_BEG;
                        end
                    end
                    default: begin
                        state <= IDLE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            case (state)
                SETUP: begin
                    src_run  <= params_i.src_s;
                    dst_run  <= params_i.dst_d;
                    val_s_o  <= params_i.src_s;                 // constant source value
                    line_cnt <= {1'b0, params_i.lines};
                end
                LINE_BEG: begin
                    line_cnt <= line_cnt - 1'b1;                // pre-decrement
                    word_cnt <= {1'b0, params_i.words} - 1'b1;
                    addr_o   <= params_i.s_const ? dst_run : src_run;
                end
                RD_S: begin
                    val_s_o  <= vram_data_i;
                    src_run  <= addr_o + 1'b1;
                    addr_o   <= dst_run;
                end
                WR_D: begin
                    dst_run  <= addr_o + 1'b1;
                    word_cnt <= word_cnt - 1'b1;
                    addr_o   <= params_i.s_const ? addr_o + 1'b1 : src_run;
                end
                LINE_END: begin
                    src_run  <= src_run + params_i.mod_s;      // end of line modulo
                    dst_run  <= dst_run + params_i.mod_d;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/blit_pixel_op.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "blit_cfg.svh"

module blit_pixel_op (
    input  wire blit_pkg::word_t        val_s_i,        // read word or constant
    input  wire blit_pkg::blit_params_t params_i,
    output blit_pkg::word_t             data_o,
    output blit_pkg::nib_mask_t         wr_mask_o
);
    import blit_pkg::*;

    word_t  d_ca;       // source with andc bits knocked out

    assign d_ca   = val_s_i & ~params_i.andc;
    assign data_o = d_ca ^ params_i.xorv;

    // transparency tests the value before the xor
    for (genvar i = 0; i < `BLIT_NIBBLES; i++) begin : g_nib
        logic [3:0] t_nib;

        // odd nibbles match the upper half of transp_t
        assign t_nib = params_i.transp_t[(i % 2) * 4 +: 4];

        assign wr_mask_o[i] = !(params_i.transp && (d_ca[i * 4 +: 4] == t_nib));
    end

endmodule

`default_nettype wire

// ==== logic/blitter_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module blitter_top (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   reg_wr_i,
    input  wire blit_pkg::blit_reg_e    reg_num_i,
    input  wire blit_pkg::word_t        reg_data_i,
    input  wire logic                   vram_ack_i,
    input  wire blit_pkg::word_t        vram_data_i,
    output blit_pkg::vram_req_t         vram_req_o,
    output logic                        busy_o,
    output logic                        full_o,
    output logic                        done_o
);
    import blit_pkg::*;

    logic           queued;
    logic           setup;
    blit_params_t   active;
    word_t          val_s;
    logic           sel;
    logic           wr;
    addr_t          addr;
    word_t          data;
    nib_mask_t      wr_mask;

    assign full_o = queued;                 // one blit waiting in the bank

    blit_regs i_regs (
        .clk        (clk),
        .reset_i    (reset_i),
        .reg_wr_i   (reg_wr_i),
        .reg_num_i  (reg_num_i),
        .reg_data_i (reg_data_i),
        .setup_i    (setup),
        .queued_o   (queued),
        .active_o   (active)
    );

    blit_seq i_seq (
        .clk         (clk),
        .reset_i     (reset_i),
        .queued_i    (queued),
        .params_i    (active),
        .vram_ack_i  (vram_ack_i),
        .vram_data_i (vram_data_i),
        .setup_o     (setup),
        .val_s_o     (val_s),
        .sel_o       (sel),
        .wr_o        (wr),
        .addr_o      (addr),
        .busy_o      (busy_o),
        .done_o      (done_o)
    );

    blit_pixel_op i_pixel_op (
        .val_s_i   (val_s),
        .params_i  (active),
        .data_o    (data),
        .wr_mask_o (wr_mask)
    );

    assign vram_req_o = '{sel: sel, wr: wr, wr_mask: wr_mask, addr: addr, data: data};

endmodule

`default_nettype wire

// ==== tests/vram_model.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "blit_cfg.svh"

module vram_model (
    input  wire logic                   clk,
    input  wire blit_pkg::vram_req_t    req_i,
    output logic                        ack_o,
    output blit_pkg::word_t             data_o      // valid while ack_o is high
);
    import blit_pkg::*;

    localparam int DEPTH = 1 << `BLIT_ADDR_W;

    word_t          mem [DEPTH];
    addr_t          log_addr [256];     // every write, in order
    word_t          log_data [256];
    nib_mask_t      log_mask [256];
    int             log_cnt;
    int             read_cnt;
    logic [31:0]    lfsr;
    int             waits;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};     // taps 32 22 2 1
    endfunction

    // 0 to 3 wait cycles, one step per bit
    task automatic draw_wait(output int n);
        n = 0;
        repeat (2) begin
            lfsr = lfsr_step(lfsr);
            n    = n * 2 + lfsr[0];
        end
    endtask

    task automatic serve_access();
        if (req_i.wr) begin
            for (int i = 0; i < `BLIT_NIBBLES; i++) begin
                if (req_i.wr_mask[i]) begin
                    mem[req_i.addr][i * 4 +: 4] = req_i.data[i * 4 +: 4];
                end
            end
            log_addr[log_cnt] = req_i.addr;
            log_data[log_cnt] = req_i.data;
            log_mask[log_cnt] = req_i.wr_mask;
            log_cnt++;
        end else begin
            data_o = mem[req_i.addr];
            read_cnt++;
        end
    endtask

    initial begin
        ack_o    = 1'b0;
        data_o   = '0;
        log_cnt  = 0;
        read_cnt = 0;
        lfsr     = 32'h7bd8;
        for (int a = 0; a < DEPTH; a++) begin
            mem[a] = word_t'(a) ^ 16'h6d2b;         // unloaded words still tell their address
        end
        forever begin
            @(posedge clk);
            #2;
            ack_o = 1'b0;
            if (req_i.sel === 1'b1) begin
                draw_wait(waits);
                repeat (waits) begin
                    @(posedge clk);
                    #2;
                end
                serve_access();
                ack_o = 1'b1;                       // request is taken at the next edge
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_blitter.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_blitter;
    import blit_pkg::*;

    localparam int MAX_REC  = 96;
    localparam int REC_VALS = 9;    // widest record is one blit

    logic       clk;
    logic       reset;
    logic       reg_wr;
    blit_reg_e  reg_num;
    word_t      reg_data;
    logic       vram_ack;
    word_t      vram_data;
    vram_req_t  vram_req;
    logic       busy;
    logic       full;
    logic       done;

    logic [7:0] rec_tag [MAX_REC];
    int         rec_val [MAX_REC * REC_VALS];
    int         rec_cnt;
    int         limit_cycles;
    logic       limit_ready;
    int         done_cnt = 0;
    int         done_goal;
    int         test_no;
    int         log_base;
    int         read_base;
    logic       expect_overlap;     // next blit queues behind a running one
    addr_t      exp_addr [$];
    word_t      exp_data [$];
    nib_mask_t  exp_mask [$];

    blitter_top i_dut (
        .clk         (clk),
        .reset_i     (reset),
        .reg_wr_i    (reg_wr),
        .reg_num_i   (reg_num),
        .reg_data_i  (reg_data),
        .vram_ack_i  (vram_ack),
        .vram_data_i (vram_data),
        .vram_req_o  (vram_req),
        .busy_o      (busy),
        .full_o      (full),
        .done_o      (done)
    );

    vram_model i_vram (
        .clk    (clk),
        .req_i  (vram_req),
        .ack_o  (vram_ack),
        .data_o (vram_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(negedge clk) begin
        if (done === 1'b1) begin
            done_cnt = done_cnt + 1;
        end
    end

    initial begin
        wait (limit_ready === 1'b1);
        repeat (limit_cycles) @(posedge clk);
        $display("watchdog fired, the blitter never finished within %0d cycles", limit_cycles);
        $display("ERRORS FOUND");
        $fatal(1, "timeout");
    end

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns, test %0d, %s got %h expected %h",
                     $time, test_no, what, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "check failed");
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns, test %0d, %s got %h expected %h",
                     $time, test_no, what, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "check failed");
        end
    endtask

    task automatic check_mask(input nib_mask_t got, input nib_mask_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns, test %0d, %s got %b expected %b",
                     $time, test_no, what, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "check failed");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns, test %0d, %s got %b expected %b",
                     $time, test_no, what, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "check failed");
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("MISMATCH at %0t ns, test %0d, %s got %0d expected %0d",
                     $time, test_no, what, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "check failed");
        end
    endtask

    function automatic int field_count(input logic [7:0] tag);
        case (tag)
            "M":     return 2;
            "B":     return REC_VALS;
            "W":     return 3;
            "G":     return 1;
            "S":     return 0;
            default: return -1;
        endcase
    endfunction

    // five cycles per budgeted step covers the longest ack wait
    function automatic int blit_budget(input int lines, input int words);
        return (lines * words * 2 + lines * 2 + 4) * 5;
    endfunction

    task automatic load_golden();
        int                 fd;
        int                 n;
        int                 r;
        int                 v;
        logic [63:0]        tag;
        logic [8*128-1:0]   skip_line;

        fd = $fopen("tests/blit_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/blit_golden.txt");
            $display("ERRORS FOUND");
            $fatal(1, "no golden file");
        end
        rec_cnt      = 0;
        limit_cycles = 40;                              // reset and final checks
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                r = $fgets(skip_line, fd);
            end else begin
                n = field_count(tag[7:0]);
                if (n < 0 || rec_cnt == MAX_REC) begin
                    $display("golden file record %0d is unknown or one too many", rec_cnt);
                    $display("ERRORS FOUND");
                    $fatal(1, "golden file format");
                end
                rec_tag[rec_cnt] = tag[7:0];
                for (int k = 0; k < n; k++) begin
                    r = $fscanf(fd, "%h", v);
                    if (r != 1) begin
                        $display("golden file record %0d ends before all its values", rec_cnt);
                        $display("ERRORS FOUND");
                        $fatal(1, "golden file format");
                    end
                    rec_val[rec_cnt * REC_VALS + k] = v;
                end
                if (tag == "B") begin
                    limit_cycles += REC_VALS + blit_budget(rec_val[rec_cnt * REC_VALS + 7] + 1,
                                                           rec_val[rec_cnt * REC_VALS + 8] + 1);
                end
                rec_cnt++;
            end
        end
        $fclose(fd);
    endtask

    task automatic write_reg(input blit_reg_e num, input int value);
        reg_wr   = 1'b1;
        reg_num  = num;
        reg_data = word_t'(value);
        @(posedge clk);
        #2;
        reg_wr   = 1'b0;
    endtask

    task automatic program_blit(input int base);
        write_reg(CTRL,  rec_val[base]);
        write_reg(ANDC,  rec_val[base + 1]);
        write_reg(XOR,   rec_val[base + 2]);
        write_reg(MOD_S, rec_val[base + 3]);
        write_reg(SRC_S, rec_val[base + 4]);
        write_reg(MOD_D, rec_val[base + 5]);
        write_reg(DST_D, rec_val[base + 6]);
        write_reg(LINES, rec_val[base + 7]);
        write_reg(WORDS, rec_val[base + 8]);            // queues the blit
        check_flag(full, 1'b1, "full_o after WORDS write");
        if (expect_overlap) begin
            check_flag(busy, 1'b1, "busy_o while second blit queued");
        end
        expect_overlap = 1'b0;
        done_goal++;
    endtask

    task automatic finish_test(input int reads);
        while (done_cnt < done_goal) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        #2;
        check_count(done_cnt, done_goal, "done_o pulses");
        check_flag(busy, 1'b0, "busy_o after last blit");
        check_flag(full, 1'b0, "full_o after last blit");
        check_flag(vram_req.sel, 1'b0, "sel after last blit");
        check_count(i_vram.read_cnt - read_base, reads, "VRAM reads");
        check_count(i_vram.log_cnt - log_base, exp_addr.size(), "VRAM writes");
        foreach (exp_addr[k]) begin
            check_addr(i_vram.log_addr[log_base + k], exp_addr[k], "write address");
            check_word(i_vram.log_data[log_base + k], exp_data[k], "write data");
            check_mask(i_vram.log_mask[log_base + k], exp_mask[k], "write mask");
        end
        $display("test %0d finished, %0d writes compared", test_no, exp_addr.size());
        log_base  = i_vram.log_cnt;
        read_base = i_vram.read_cnt;
        exp_addr.delete();
        exp_data.delete();
        exp_mask.delete();
        test_no++;
    endtask

    task automatic run_record(input int idx);
        int base;

        base = idx * REC_VALS;
        case (rec_tag[idx])
            "M": begin
                i_vram.mem[rec_val[base]] = word_t'(rec_val[base + 1]);
            end
            "B": begin
                program_blit(base);
            end
            "S": begin
                expect_overlap = 1'b1;
                while (busy !== 1'b1) begin
                    @(posedge clk);
                    #2;
                end
            end
            "W": begin
                exp_addr.push_back(addr_t'(rec_val[base]));
                exp_data.push_back(word_t'(rec_val[base + 1]));
                exp_mask.push_back(nib_mask_t'(rec_val[base + 2]));
            end
            "G": begin
                finish_test(rec_val[base]);
            end
            default: begin
            end
        endcase
    endtask

    initial begin
        reset          = 1'b1;
        reg_wr         = 1'b0;
        reg_num        = CTRL;
        reg_data       = '0;
        limit_ready    = 1'b0;
        done_goal      = 0;
        test_no        = 1;
        expect_overlap = 1'b0;
        load_golden();
        limit_ready = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        check_flag(busy, 1'b0, "busy_o after reset");
        check_flag(full, 1'b0, "full_o after reset");
        check_flag(done, 1'b0, "done_o after reset");
        check_flag(vram_req.sel, 1'b0, "sel after reset");
        log_base  = i_vram.log_cnt;
        read_base = i_vram.read_cnt;
        for (int i = 0; i < rec_cnt; i++) begin
            run_record(i);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+logic
logic/blit_pkg.sv
logic/blit_regs.sv
logic/blit_seq.sv
logic/blit_pixel_op.sv
logic/blitter_top.sv
tests/vram_model.sv
tests/tb_blitter.sv

// ==== tests/blit_golden.txt ====
# M addr data = preload word, B ctrl andc xor mod_s src_s mod_d dst_d lines words = one blit
# S = wait for busy, W addr data mask = expected write in order, G reads = run and check, all hex
# one-line copy
M 0100 1234  M 0101 5678  M 0102 9abc  M 0103 def0
B 0000 0000 0000 0000 0100 0000 0200 0000 0003
W 0200 1234 f  W 0201 5678 f  W 0202 9abc f  W 0203 def0 f
G 4
# two by three copy with source and destination modulos
M 0300 a001  M 0301 a002  M 0302 a003
M 0308 b001  M 0309 b002  M 030a b003
B 0000 0000 0000 0005 0300 000d 0400 0001 0002
W 0400 a001 f  W 0401 a002 f  W 0402 a003 f
W 0410 b001 f  W 0411 b002 f  W 0412 b003 f
G 6
# constant fill through andc and xor
B 0001 000f 1100 0000 c35a 0006 0500 0001 0001
W 0500 d250 f  W 0501 d250 f  W 0508 d250 f  W 0509 d250 f
G 0
# andc and xor with 4-bit transparency, odd nibbles 7 and even nibbles 0
M 0600 7e35  M 0601 1770  M 0602 2a4b
B 7010 0f00 0ff0 0000 0600 0000 0700 0000 0002
W 0700 7fc5 3  W 0701 1f80 8  W 0702 2fbb b
G 3
# copy with a fill queued while it runs
B 0000 0000 0000 0005 0300 0000 0800 0001 0002
S
B 0001 0000 0000 0000 5a5a 0000 0900 0000 0001
W 0800 a001 f  W 0801 a002 f  W 0802 a003 f
W 0803 b001 f  W 0804 b002 f  W 0805 b003 f
W 0900 5a5a f  W 0901 5a5a f
G 6
